// ==== rtl/cache_geom_pkg.sv ====
// cache line store geometry: widths, vector types and the internal line request
package cache_geom_pkg;

    // word and line sizes
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 512;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;

    // byte address layout: line index, word offset, byte offset
    localparam int BYTE_OFF_W = 2;
    localparam int WORD_OFF_W = 4;
    localparam int LINE_IDX_W = 6;
    localparam int ADDR_W     = LINE_IDX_W + WORD_OFF_W + BYTE_OFF_W;

    // one strobe per byte of a word
    localparam int STRB_W = WORD_W / 8;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_IDX_W-1:0] line_idx_t;
    typedef logic [WORD_OFF_W-1:0] word_off_t;
    typedef logic [STRB_W-1:0]     strb_t;

    // request from the front end to the store and the response unit
    typedef struct packed {
        logic      write;
        line_idx_t line_idx;
        word_off_t offset;
        // write word repeated in every slot of the line
        line_t     wline;
        // set bits are the ones the write replaces
        line_t     wmask;
    } line_req_t;

endpackage

// ==== rtl/axil_pkg.sv ====
// AXI4-Lite channel payloads and response codes for the line store port
package axil_pkg;

    import cache_geom_pkg::*;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [1:0]        resp_t;

    // only OKAY is ever returned, the address space maps onto the store
    localparam resp_t RESP_OKAY = 2'b00;

    // write address channel
    typedef struct packed {
        addr_t addr;
    } axil_aw_t;

    // write data channel
    typedef struct packed {
        word_t data;
        strb_t strb;
    } axil_w_t;

    // write response channel
    typedef struct packed {
        resp_t resp;
    } axil_b_t;

    // read address channel
    typedef struct packed {
        addr_t addr;
    } axil_ar_t;

    // read data channel
    typedef struct packed {
        word_t data;
        resp_t resp;
    } axil_r_t;

endpackage

// ==== rtl/axil_req_front.sv ====
// AXI4-Lite request front end: holds AW, W and AR and issues line requests with a bit mask
`timescale 1ns/100ps

module axil_req_front
    import cache_geom_pkg::*;
    import axil_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  axil_aw_t  aw,
    input  logic      aw_valid,
    output logic      aw_ready,

    input  axil_w_t   w,
    input  logic      w_valid,
    output logic      w_ready,

    input  axil_ar_t  ar,
    input  logic      ar_valid,
    output logic      ar_ready,

    input  logic      resp_busy,
    output line_req_t req,
    output logic      req_valid
);

    // one-deep holding registers per channel
    axil_aw_t aw_q;
    axil_w_t  w_q;
    axil_ar_t ar_q;
    logic     aw_full;
    logic     w_full;
    logic     ar_full;

    logic     issue_wr;
    logic     issue_rd;
    addr_t    sel_addr;
    word_t    ext_strb;

    assign aw_ready = !aw_full;
    assign w_ready  = !w_full;
    assign ar_ready = !ar_full;

    // a complete write always wins over a pending read
    assign issue_wr = aw_full && w_full && !resp_busy;
    assign issue_rd = ar_full && !resp_busy && !(aw_full && w_full);
    assign req_valid = issue_wr || issue_rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            ar_full <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_full <= 1'b1;
            end else if (issue_wr) begin
                aw_full <= 1'b0;
            end
            if (w_valid && w_ready) begin
                w_full <= 1'b1;
            end else if (issue_wr) begin
                w_full <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                ar_full <= 1'b1;
            end else if (issue_rd) begin
                ar_full <= 1'b0;
            end
        end
    end

    // payloads load on acceptance only
    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            aw_q <= aw;
        end
        if (w_valid && w_ready) begin
            w_q <= w;
        end
        if (ar_valid && ar_ready) begin
            ar_q <= ar;
        end
    end

    assign sel_addr = issue_wr ? aw_q.addr : ar_q.addr;

    // widen each strobe bit to a byte lane
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            ext_strb[b*8 +: 8] = {8{w_q.strb[b]}};
        end
    end

    always_comb begin
        req.write    = issue_wr;
        req.line_idx = sel_addr[ADDR_W-1 -: LINE_IDX_W];
        req.offset   = sel_addr[BYTE_OFF_W +: WORD_OFF_W];
        req.wline    = {WORDS_PER_LINE{w_q.data}};
        // mask is the widened strobe in the addressed word slot only
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            if (req.offset == word_off_t'(i)) begin
                req.wmask[i*WORD_W +: WORD_W] = ext_strb;
            end else begin
                req.wmask[i*WORD_W +: WORD_W] = '0;
            end
        end
    end

endmodule

// ==== rtl/line_sram.sv ====
// synchronous line store with bit-masked writes and a registered read address
`timescale 1ns/100ps

module line_sram
    import cache_geom_pkg::*;
#(
    parameter int LINE_COUNT = 2 ** LINE_IDX_W
) (
    input  logic      clk,

    input  line_req_t req,
    input  logic      req_valid,

    output line_t     rline
);

    line_t     mem [0:LINE_COUNT-1];
    line_idx_t raddr_q;

    logic      do_write;
    logic      do_read;
    line_t     old_line;
    line_t     new_line;

    assign do_write = req_valid && req.write;
    assign do_read  = req_valid && !req.write;

    // read-modify-write of the addressed line
    assign old_line = mem[req.line_idx];
    assign new_line = (old_line & ~req.wmask) | (req.wline & req.wmask);

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[req.line_idx] <= new_line;
        end
    end

    // read address only moves on a read, so rline stays put across writes
    always_ff @(posedge clk) begin
        if (do_read) begin
            raddr_q <= req.line_idx;
        end
    end

    assign rline = mem[raddr_q];

endmodule

// ==== rtl/line_resp_unit.sv ====
// response unit: picks the word out of the read line and drives the B and R channels
`timescale 1ns/100ps

module line_resp_unit
    import cache_geom_pkg::*;
    import axil_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  line_req_t req,
    input  logic      req_valid,
    input  line_t     rline,

    output axil_b_t   b,
    output logic      b_valid,
    input  logic      b_ready,

    output axil_r_t   r,
    output logic      r_valid,
    input  logic      r_ready,

    output logic      resp_busy
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } state_e;

    state_e    state;
    word_off_t rd_off_q;
    word_t     rd_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= req.write ? WRITE_RESP : READ_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (b_ready) begin
                        state <= IDLE;
                    end
                end
                READ_RESP: begin
                    if (r_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // word offset of the read in flight
    always_ff @(posedge clk) begin
        if (req_valid && !req.write) begin
            rd_off_q <= req.offset;
        end
    end

    // front end waits while a response is outstanding
    assign resp_busy = (state != IDLE);

    assign rd_word = rline[rd_off_q*WORD_W +: WORD_W];

    assign b_valid = (state == WRITE_RESP);
    assign b.resp  = RESP_OKAY;

    assign r_valid = (state == READ_RESP);
    assign r.data  = rd_word;
    assign r.resp  = RESP_OKAY;

endmodule

// ==== rtl/line_store_top.sv ====
// line store top: AXI4-Lite front end, line SRAM and response unit
`timescale 1ns/100ps

module line_store_top
    import cache_geom_pkg::*;
    import axil_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  axil_aw_t aw,
    input  logic     aw_valid,
    output logic     aw_ready,

    input  axil_w_t  w,
    input  logic     w_valid,
    output logic     w_ready,

    input  axil_ar_t ar,
    input  logic     ar_valid,
    output logic     ar_ready,

    output axil_b_t  b,
    output logic     b_valid,
    input  logic     b_ready,

    output axil_r_t  r,
    output logic     r_valid,
    input  logic     r_ready
);

    line_req_t req;
    logic      req_valid;
    logic      resp_busy;
    line_t     rline;

    axil_req_front u_front (
        .clk       (clk),
        .reset     (reset),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .resp_busy (resp_busy),
        .req       (req),
        .req_valid (req_valid)
    );

    line_sram u_sram (
        .clk       (clk),
        .req       (req),
        .req_valid (req_valid),
        .rline     (rline)
    );

    line_resp_unit u_resp (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .rline     (rline),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .resp_busy (resp_busy)
    );

endmodule

// ==== test/line_store_checker.sv ====
// protocol checker for the line store B and R channels, bound into the top level
`timescale 1ns/100ps

module line_store_checker
    import axil_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input axil_b_t b,
    input logic    b_valid,
    input logic    b_ready,
    input axil_r_t r,
    input logic    r_valid,
    input logic    r_ready
);

    // assertion failures so far
    int fail_count = 0;

    valid_low_after_reset: assert property (@(posedge clk) reset |=> !b_valid && !r_valid)
        else begin
            $error("B or R valid is high right after reset");
            fail_count++;
        end

    // payload must hold while the master stalls
    b_stable: assert property (@(posedge clk) disable iff (reset)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else begin
            $error("B channel dropped valid or changed payload before the handshake");
            fail_count++;
        end

    r_stable: assert property (@(posedge clk) disable iff (reset)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            $error("R channel dropped valid or changed payload before the handshake");
            fail_count++;
        end

    b_okay: assert property (@(posedge clk) disable iff (reset) b_valid |-> b.resp == RESP_OKAY)
        else begin
            $error("B response is not OKAY");
            fail_count++;
        end

    r_okay: assert property (@(posedge clk) disable iff (reset) r_valid |-> r.resp == RESP_OKAY)
        else begin
            $error("R response is not OKAY");
            fail_count++;
        end

endmodule

bind line_store_top line_store_checker protocol_chk (.*);

// ==== test/line_store_tb.sv ====
// testbench for the line store: AXI4-Lite stimulus, reference word model and data checks
`timescale 1ns/100ps

module line_store_tb
    import cache_geom_pkg::*;
    import axil_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int WORD_COUNT = 2 ** (ADDR_W - BYTE_OFF_W);
    localparam int MIX_COUNT  = 200;
    // preload, 60 directed transactions, then the random mix
    localparam int TXN_COUNT  = WORD_COUNT + 60 + MIX_COUNT;

    logic     clk;
    logic     reset;
    axil_aw_t aw;
    axil_w_t  w;
    axil_ar_t ar;
    axil_b_t  b;
    axil_r_t  r;
    logic     aw_valid;
    logic     aw_ready;
    logic     w_valid;
    logic     w_ready;
    logic     ar_valid;
    logic     ar_ready;
    logic     b_valid;
    logic     b_ready;
    logic     r_valid;
    logic     r_ready;

    // expected contents by word address
    word_t    ref_mem [0:WORD_COUNT-1];
    int       errors;

    line_store_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // order 0 presents AW and W together, 1 puts AW first, 2 puts W first
    // bready is held low for a random 0 to 3 cycles once bvalid is up
    task automatic write_word(input string name, input addr_t addr, input word_t data,
                              input strb_t strb, input int order);
        bit aw_done;
        bit w_done;
        int cyc;
        int aw_at;
        int w_at;
        int gap;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cyc     = 0;
        aw_at   = (order == 2) ? 3 : 0;
        w_at    = (order == 1) ? 3 : 0;
        while (!(aw_done && w_done)) begin
            if (cyc == aw_at) begin
                aw.addr  <= addr;
                aw_valid <= 1'b1;
            end
            if (cyc == w_at) begin
                w       <= '{data, strb};
                w_valid <= 1'b1;
            end
            @(posedge clk);
            cyc++;
            assert (!b_valid) else begin
                errors++;
                $display("%s: write response came before address and data were both taken", name);
            end
            if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_valid && w_ready) begin
                w_valid <= 1'b0;
                w_done = 1'b1;
            end
        end
        for (int k = 0; k < STRB_W; k++) begin
            if (strb[k]) begin
                ref_mem[addr[ADDR_W-1:BYTE_OFF_W]][k*8 +: 8] = data[k*8 +: 8];
            end
        end
        gap = $urandom_range(3, 0);
        b_ready <= (gap == 0);
        do begin
            @(posedge clk);
            if (b_valid && !b_ready) begin
                gap--;
                if (gap <= 0) begin
                    b_ready <= 1'b1;
                end
            end
        end while (!(b_valid && b_ready));
        b_ready <= 1'b0;
        assert (b.resp == RESP_OKAY) else begin
            errors++;
            $display("[FAIL] %s: bresp expected %0h, actual %0h", name, RESP_OKAY, b.resp);
        end
    endtask

    // rready stays low for up to max_gap cycles once rvalid is up
    task automatic read_word(input string name, input addr_t addr, input int max_gap);
        word_t exp;
        int    gap;
        bit    done;
        exp  = ref_mem[addr[ADDR_W-1:BYTE_OFF_W]];
        gap  = $urandom_range(max_gap, 0);
        done = 1'b0;
        ar.addr  <= addr;
        ar_valid <= 1'b1;
        r_ready  <= (gap == 0);
        while (!done) begin
            @(posedge clk);
            if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
            end
            if (r_valid && r_ready) begin
                r_ready <= 1'b0;
                done = 1'b1;
                assert (r.data === exp) else begin
                    errors++;
                    $display("[FAIL] %s: addr %h expected %h, actual %h", name, addr, exp, r.data);
                end
            end else if (r_valid) begin
                gap--;
                if (gap <= 0) begin
                    r_ready <= 1'b1;
                end
            end
        end
    endtask

    initial begin
        addr_t a;
        strb_t s;
        int    line;
        void'($urandom(96));
        errors   = 0;
        reset    = 1'b1;
        aw       = '0;
        w        = '0;
        ar       = '0;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        ar_valid = 1'b0;
        b_ready  = 1'b0;
        r_ready  = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // fill pattern built from the whole word address
        for (int i = 0; i < WORD_COUNT; i++) begin
            write_word("preload", addr_t'(i << 2), {i[9:0], ~i[9:0], 12'h5c3}, 4'hf, 0);
        end

        a = addr_t'($urandom);
        write_word("full_write", a, $urandom, 4'hf, 0);
        read_word("full_write", a, 0);

        // old bytes survive where the strobe is clear
        a = addr_t'($urandom);
        s = strb_t'($urandom_range(14, 1));
        write_word("partial_strobe", a, $urandom, s, 0);
        read_word("partial_strobe", a, 0);

        line = $urandom_range(2 ** LINE_IDX_W - 1, 0);
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            a = {line_idx_t'(line), word_off_t'(i), 2'b00};
            write_word("line_fill", a, {16'hc0de, 8'(line), 8'(i)}, 4'hf, 0);
        end
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            read_word("line_fill", {line_idx_t'(line), word_off_t'(i), 2'b00}, 0);
        end

        repeat (20) begin
            read_word("ready_gap", addr_t'($urandom), 6);
        end

        for (int order = 1; order <= 2; order++) begin
            a = addr_t'($urandom);
            write_word("split_aw_w", a, $urandom, 4'hf, order);
            read_word("split_aw_w", a, 0);
        end

        // a few lines only, so reads often hit freshly written words
        repeat (MIX_COUNT) begin
            a = {line_idx_t'($urandom_range(3, 0)), word_off_t'($urandom), 2'($urandom)};
            if ($urandom_range(1, 0) == 1) begin
                write_word("random_mix", a, $urandom, strb_t'($urandom), $urandom_range(2, 0));
            end else begin
                read_word("random_mix", a, 3);
            end
        end

        repeat (2) @(posedge clk);
        $display("errors: data %0d, protocol %0d", errors, dut.protocol_chk.fail_count);
        if (errors == 0 && dut.protocol_chk.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog allows 40 cycles per transaction
    initial begin
        #(TXN_COUNT * 40 * CLK_PERIOD);
        $display("timeout: the DUT stopped answering before all transactions completed");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/cache_geom_pkg.sv
rtl/axil_pkg.sv
rtl/axil_req_front.sv
rtl/line_sram.sv
rtl/line_resp_unit.sv
rtl/line_store_top.sv
test/line_store_checker.sv
test/line_store_tb.sv

// ==== Bender.yml ====
package:
  name: line_store

sources:
  - rtl/cache_geom_pkg.sv
  - rtl/axil_pkg.sv
  - rtl/axil_req_front.sv
  - rtl/line_sram.sv
  - rtl/line_resp_unit.sv
  - rtl/line_store_top.sv
  - target: test
    files:
      - test/line_store_checker.sv
      - test/line_store_tb.sv
